// ==== Makefile ====
TOP = top_rtl_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(wildcard src/*.sv) verification/top_rtl_tb.sv
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module top_rtl

clean:
	rm -rf obj_dir $(LOG)

// ==== src/enemy_control.sv ====
// enemy_control: enemy position that chases the cursor once per frame
`timescale 1ns/10ps
`default_nettype none

module enemy_control (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                frame_done,
    input  wire  [vector_pkg::COORD_WIDTH-1:0] x_cursor,
    input  wire  [vector_pkg::COORD_WIDTH-1:0] y_cursor,
    output logic [vector_pkg::COORD_WIDTH-1:0] x_enemy,
    output logic [vector_pkg::COORD_WIDTH-1:0] y_enemy,
    output logic                               enemy_hit
);

    logic [vector_pkg::COORD_WIDTH-1:0] x_next;
    logic [vector_pkg::COORD_WIDTH-1:0] y_next;
    logic                               caught;

    // one unit toward the cursor per axis
    always_comb begin
        if (x_enemy < x_cursor) begin
            x_next = x_enemy + 1'b1;
        end else if (x_enemy > x_cursor) begin
            x_next = x_enemy - 1'b1;
        end else begin
            x_next = x_enemy;
        end

        if (y_enemy < y_cursor) begin
            y_next = y_enemy + 1'b1;
        end else if (y_enemy > y_cursor) begin
            y_next = y_enemy - 1'b1;
        end else begin
            y_next = y_enemy;
        end
    end

    assign caught = (x_next == x_cursor) && (y_next == y_cursor);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_enemy   <= sprite_pkg::SPAWN_X;
            y_enemy   <= sprite_pkg::SPAWN_Y;
            enemy_hit <= 1'b0;
        end else begin
            enemy_hit <= 1'b0;
            if (frame_done) begin
                if (caught) begin
                    // landed on the cursor, back to the corner
                    x_enemy   <= sprite_pkg::SPAWN_X;
                    y_enemy   <= sprite_pkg::SPAWN_Y;
                    enemy_hit <= 1'b1;
                end else begin
                    x_enemy <= x_next;
                    y_enemy <= y_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/frame_ram.sv ====
// frame_ram: point buffer with one write port and one registered read port
`timescale 1ns/10ps
`default_nettype none

module frame_ram (
    input  wire                                clk,
    input  wire  [vector_pkg::ADDR_WIDTH-1:0]  wr_addr,
    input  wire  [vector_pkg::POINT_WIDTH-1:0] wr_data,
    input  wire                                we,
    input  wire  [vector_pkg::ADDR_WIDTH-1:0]  rd_addr,
    output logic [vector_pkg::POINT_WIDTH-1:0] rd_data
);

    logic [vector_pkg::POINT_WIDTH-1:0] mem [0:vector_pkg::RAM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data valid one clock after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== src/memory_manage.sv ====
// memory_manage: frame builder copying offset sprite points into the frame RAM
`timescale 1ns/10ps
`default_nettype none

module memory_manage (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  [vector_pkg::COORD_WIDTH-1:0] x_cursor,
    input  wire  [vector_pkg::COORD_WIDTH-1:0] y_cursor,
    input  wire  [vector_pkg::COORD_WIDTH-1:0] x_enemy,
    input  wire  [vector_pkg::COORD_WIDTH-1:0] y_enemy,
    output logic [vector_pkg::ADDR_WIDTH-1:0]  rom_addr,
    input  wire  [vector_pkg::POINT_WIDTH-1:0] rom_data,
    output logic [vector_pkg::ADDR_WIDTH-1:0]  ram_wr_addr,
    output logic [vector_pkg::POINT_WIDTH-1:0] ram_wr_data,
    output logic                               ram_we,
    output logic                               draw_frame,
    input  wire                                frame_done
);

    vector_pkg::build_state_t state;

    logic [vector_pkg::ADDR_WIDTH-1:0]  point_cnt;
    logic [vector_pkg::ADDR_WIDTH-1:0]  wr_ptr;
    logic [vector_pkg::COORD_WIDTH-1:0] x_cursor_q;
    logic [vector_pkg::COORD_WIDTH-1:0] y_cursor_q;
    logic [vector_pkg::COORD_WIDTH-1:0] x_enemy_q;
    logic [vector_pkg::COORD_WIDTH-1:0] y_enemy_q;
    logic [vector_pkg::COORD_WIDTH-1:0] x_off;
    logic [vector_pkg::COORD_WIDTH-1:0] y_off;
    logic [vector_pkg::COORD_WIDTH-1:0] x_point;
    logic [vector_pkg::COORD_WIDTH-1:0] y_point;
    logic                               first_cycle;

    ////////////////////////////////////////////////////////////////////////////
    // offset and write datapath
    ////////////////////////////////////////////////////////////////////////////
    assign first_cycle = (state == vector_pkg::COPY_CURSOR) && (point_cnt == '0);

    // cursor goes straight through on the sampling cycle
    always_comb begin
        if (first_cycle) begin
            x_off = x_cursor;
            y_off = y_cursor;
        end else if (state == vector_pkg::COPY_ENEMY) begin
            x_off = x_enemy_q;
            y_off = y_enemy_q;
        end else begin
            x_off = x_cursor_q;
            y_off = y_cursor_q;
        end
    end

    // 8-bit sums wrap at the screen edge
    assign x_point = rom_data[vector_pkg::X_LSB +: vector_pkg::COORD_WIDTH] + x_off;
    assign y_point = rom_data[vector_pkg::Y_LSB +: vector_pkg::COORD_WIDTH] + y_off;

    assign rom_addr = (state == vector_pkg::COPY_ENEMY) ?
                      sprite_pkg::ENEMY_BASE + point_cnt :
                      sprite_pkg::CURSOR_BASE + point_cnt;

    assign ram_we = (state == vector_pkg::COPY_CURSOR) ||
                    (state == vector_pkg::COPY_ENEMY) ||
                    (state == vector_pkg::WRITE_END);

    assign ram_wr_addr = wr_ptr;
    assign ram_wr_data = (state == vector_pkg::WRITE_END) ? vector_pkg::END_WORD :
                         {rom_data[vector_pkg::END_BIT], rom_data[vector_pkg::BEAM_BIT],
                          y_point, x_point};

    assign draw_frame = (state == vector_pkg::DRAW);

    // offsets held for the rest of the build
    always_ff @(posedge clk) begin
        if (first_cycle) begin
            x_cursor_q <= x_cursor;
            y_cursor_q <= y_cursor;
            x_enemy_q  <= x_enemy;
            y_enemy_q  <= y_enemy;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // build / draw FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= vector_pkg::IDLE;
            point_cnt <= '0;
            wr_ptr    <= '0;
        end else begin
            case (state)
                vector_pkg::IDLE: begin
                    point_cnt <= '0;
                    wr_ptr    <= '0;
                    state     <= vector_pkg::COPY_CURSOR;
                end
                vector_pkg::COPY_CURSOR: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (point_cnt == sprite_pkg::CURSOR_LEN - 1'b1) begin
                        point_cnt <= '0;
                        state     <= vector_pkg::COPY_ENEMY;
                    end else begin
                        point_cnt <= point_cnt + 1'b1;
                    end
                end
                vector_pkg::COPY_ENEMY: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (point_cnt == sprite_pkg::ENEMY_LEN - 1'b1) begin
                        point_cnt <= '0;
                        state     <= vector_pkg::WRITE_END;
                    end else begin
                        point_cnt <= point_cnt + 1'b1;
                    end
                end
                vector_pkg::WRITE_END: begin
                    state <= vector_pkg::DRAW;
                end
                vector_pkg::DRAW: begin
                    // RAM untouched until the display has finished
                    if (frame_done) begin
                        state <= vector_pkg::IDLE;
                    end
                end
                default: begin
                    state <= vector_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/sprite_pkg.sv ====
// sprite_pkg: outline point tables for the cursor and enemy shapes, spawn corner
`default_nettype none

package sprite_pkg;

    // shape placement inside the table
    localparam logic [vector_pkg::ADDR_WIDTH-1:0] CURSOR_BASE = 10'd0;
    localparam logic [vector_pkg::ADDR_WIDTH-1:0] CURSOR_LEN  = 10'd6;
    localparam logic [vector_pkg::ADDR_WIDTH-1:0] ENEMY_BASE  = 10'd6;
    localparam logic [vector_pkg::ADDR_WIDTH-1:0] ENEMY_LEN   = 10'd8;

    localparam logic [vector_pkg::ADDR_WIDTH-1:0] SPRITE_LEN = ENEMY_BASE + ENEMY_LEN;
    localparam int SPRITE_IDX_WIDTH = $clog2(SPRITE_LEN);

    // enemy respawn corner
    localparam logic [vector_pkg::COORD_WIDTH-1:0] SPAWN_X = 8'd240;
    localparam logic [vector_pkg::COORD_WIDTH-1:0] SPAWN_Y = 8'd240;

    ////////////////////////////////////////////////////////////////////////////
    // point words {end, beam, y, x}, relative to the shape origin
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [vector_pkg::POINT_WIDTH-1:0] SPRITE_TABLE [0:SPRITE_LEN-1] = '{
        // cursor, crosshair with a short centre tick
        {1'b0, 1'b0, 8'd0, 8'd4},
        {1'b0, 1'b1, 8'd8, 8'd4},
        {1'b0, 1'b0, 8'd4, 8'd0},
        {1'b0, 1'b1, 8'd4, 8'd8},
        {1'b0, 1'b0, 8'd3, 8'd3},
        {1'b0, 1'b1, 8'd5, 8'd5},
        // enemy, diamond with an inner bar
        {1'b0, 1'b0, 8'd0, 8'd4},
        {1'b0, 1'b1, 8'd4, 8'd8},
        {1'b0, 1'b1, 8'd8, 8'd4},
        {1'b0, 1'b1, 8'd4, 8'd0},
        {1'b0, 1'b1, 8'd0, 8'd4},
        {1'b0, 1'b0, 8'd4, 8'd2},
        {1'b0, 1'b1, 8'd4, 8'd6},
        {1'b0, 1'b1, 8'd6, 8'd4}
    };

endpackage

`default_nettype wire

// ==== src/sprite_rom.sv ====
// sprite_rom: combinational lookup of sprite outline points by address
`timescale 1ns/10ps
`default_nettype none

module sprite_rom (
    input  wire  [vector_pkg::ADDR_WIDTH-1:0]  addr,
    output logic [vector_pkg::POINT_WIDTH-1:0] data
);

    logic                                  in_table;
    logic [sprite_pkg::SPRITE_IDX_WIDTH-1:0] index;

    assign in_table = (addr < sprite_pkg::SPRITE_LEN);
    assign index    = addr[sprite_pkg::SPRITE_IDX_WIDTH-1:0];

    // anything past the shapes reads as a blanked end word
    always_comb begin
        if (in_table) begin
            data = sprite_pkg::SPRITE_TABLE[index];
        end else begin
            data = vector_pkg::END_WORD;
        end
    end

endmodule

`default_nettype wire

// ==== src/top_rtl.sv ====
// top_rtl: vector display game core, sprite ROM to frame RAM to DAC outputs
`timescale 1ns/10ps
`default_nettype none

module top_rtl (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  [vector_pkg::COORD_WIDTH-1:0] x_cursor,
    input  wire  [vector_pkg::COORD_WIDTH-1:0] y_cursor,
    output logic [vector_pkg::COORD_WIDTH-1:0] xch,
    output logic [vector_pkg::COORD_WIDTH-1:0] ych,
    output logic                               beam_on,
    output logic                               dac_load,
    output logic                               enemy_hit
);

    // ROM side
    logic [vector_pkg::ADDR_WIDTH-1:0]  rom_addr;
    logic [vector_pkg::POINT_WIDTH-1:0] rom_data;

    // RAM side
    logic [vector_pkg::ADDR_WIDTH-1:0]  ram_wr_addr;
    logic [vector_pkg::POINT_WIDTH-1:0] ram_wr_data;
    logic                               ram_we;
    logic [vector_pkg::ADDR_WIDTH-1:0]  ram_rd_addr;
    logic [vector_pkg::POINT_WIDTH-1:0] ram_rd_data;

    // frame handshake and enemy position
    logic                               draw_frame;
    logic                               frame_done;
    logic [vector_pkg::COORD_WIDTH-1:0] x_enemy;
    logic [vector_pkg::COORD_WIDTH-1:0] y_enemy;

    sprite_rom u_sprite_rom (
        .addr (rom_addr),
        .data (rom_data)
    );

    frame_ram u_frame_ram (
        .clk     (clk),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .we      (ram_we),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    enemy_control u_enemy_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_done (frame_done),
        .x_cursor   (x_cursor),
        .y_cursor   (y_cursor),
        .x_enemy    (x_enemy),
        .y_enemy    (y_enemy),
        .enemy_hit  (enemy_hit)
    );

    memory_manage u_memory_manage (
        .clk         (clk),
        .rst_n       (rst_n),
        .x_cursor    (x_cursor),
        .y_cursor    (y_cursor),
        .x_enemy     (x_enemy),
        .y_enemy     (y_enemy),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data),
        .ram_we      (ram_we),
        .draw_frame  (draw_frame),
        .frame_done  (frame_done)
    );

    vector_display u_vector_display (
        .clk         (clk),
        .rst_n       (rst_n),
        .draw_frame  (draw_frame),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_data (ram_rd_data),
        .xch         (xch),
        .ych         (ych),
        .beam_on     (beam_on),
        .dac_load    (dac_load),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

// ==== src/vector_display.sv ====
// vector_display: point sequencer driving the X/Y DAC codes, beam and load strobe
`timescale 1ns/10ps
`default_nettype none

module vector_display (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                draw_frame,
    output logic [vector_pkg::ADDR_WIDTH-1:0]  ram_rd_addr,
    input  wire  [vector_pkg::POINT_WIDTH-1:0] ram_rd_data,
    output logic [vector_pkg::COORD_WIDTH-1:0] xch,
    output logic [vector_pkg::COORD_WIDTH-1:0] ych,
    output logic                               beam_on,
    output logic                               dac_load,
    output logic                               frame_done
);

    vector_pkg::display_state_t state;

    logic [vector_pkg::DWELL_WIDTH-1:0] dwell_cnt;
    logic                               end_word;

    assign end_word = ram_rd_data[vector_pkg::END_BIT];

    ////////////////////////////////////////////////////////////////////////////
    // the read address runs one point ahead, so the word is ready at FETCH
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= vector_pkg::WAIT;
            ram_rd_addr <= '0;
            dwell_cnt   <= '0;
            xch         <= '0;
            ych         <= '0;
            beam_on     <= 1'b0;
            dac_load    <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            dac_load   <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                vector_pkg::WAIT: begin
                    if (draw_frame) begin
                        state <= vector_pkg::FETCH;
                    end
                end
                vector_pkg::FETCH: begin
                    if (end_word) begin
                        // end marker, nothing goes to the DAC
                        beam_on    <= 1'b0;
                        frame_done <= 1'b1;
                        state      <= vector_pkg::DONE;
                    end else begin
                        xch         <= ram_rd_data[vector_pkg::X_LSB +: vector_pkg::COORD_WIDTH];
                        ych         <= ram_rd_data[vector_pkg::Y_LSB +: vector_pkg::COORD_WIDTH];
                        beam_on     <= ram_rd_data[vector_pkg::BEAM_BIT];
                        dac_load    <= 1'b1;
                        ram_rd_addr <= ram_rd_addr + 1'b1;
                        dwell_cnt   <= '0;
                        state       <= vector_pkg::HOLD;
                    end
                end
                vector_pkg::HOLD: begin
                    if (dwell_cnt == vector_pkg::DWELL_LAST) begin
                        state <= vector_pkg::FETCH;
                    end else begin
                        dwell_cnt <= dwell_cnt + 1'b1;
                    end
                end
                vector_pkg::DONE: begin
                    // rewind for the next frame
                    ram_rd_addr <= '0;
                    state       <= vector_pkg::WAIT;
                end
                default: begin
                    state <= vector_pkg::WAIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/vector_pkg.sv ====
// vector_pkg: point word layout, widths, frame RAM size, dwell time and FSM states
`default_nettype none

package vector_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int COORD_WIDTH  = 8;
    localparam int POINT_WIDTH  = 18;
    localparam int ADDR_WIDTH   = 10;
    localparam int RAM_DEPTH    = 1000;

    // point word fields
    localparam int X_LSB    = 0;
    localparam int Y_LSB    = 8;
    localparam int BEAM_BIT = 16;
    localparam int END_BIT  = 17;

    // end marker, beam off and parked at the origin
    localparam logic [POINT_WIDTH-1:0] END_WORD = {1'b1, 1'b0, 8'd0, 8'd0};

    // clocks per point on the DAC
    localparam int DWELL_CYCLES = 4;
    localparam int DWELL_WIDTH  = $clog2(DWELL_CYCLES);
    localparam logic [DWELL_WIDTH-1:0] DWELL_LAST = DWELL_WIDTH'(DWELL_CYCLES - 1);

    ////////////////////////////////////////////////////////////////////////////
    // state encodings
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        COPY_CURSOR,
        COPY_ENEMY,
        WRITE_END,
        DRAW
    } build_state_t;

    typedef enum logic [1:0] {
        WAIT,
        FETCH,
        HOLD,
        DONE
    } display_state_t;

endpackage

`default_nettype wire

// ==== verification/top_rtl_tb.sv ====
// top_rtl_tb: self-checking testbench for the vector display core, driven by a vectors file
`timescale 1ns/10ps
`default_nettype none

module top_rtl_tb;

    localparam int    CLK_PERIOD  = 20;
    localparam int    CURSOR_PTS  = int'(sprite_pkg::CURSOR_LEN);
    localparam int    SHAPE_PTS   = CURSOR_PTS + int'(sprite_pkg::ENEMY_LEN);
    localparam string VECTOR_FILE = "verification/top_rtl_vectors.txt";

    logic                               clk;
    logic                               rst_n;
    logic [vector_pkg::COORD_WIDTH-1:0] x_cursor;
    logic [vector_pkg::COORD_WIDTH-1:0] y_cursor;
    wire  [vector_pkg::COORD_WIDTH-1:0] xch;
    wire  [vector_pkg::COORD_WIDTH-1:0] ych;
    wire                                beam_on;
    wire                                dac_load;
    wire                                enemy_hit;

    // one entry per frame
    logic [vector_pkg::COORD_WIDTH-1:0] cursor_x_q [$];
    logic [vector_pkg::COORD_WIDTH-1:0] cursor_y_q [$];
    logic [vector_pkg::COORD_WIDTH-1:0] enemy_x_q  [$];
    logic [vector_pkg::COORD_WIDTH-1:0] enemy_y_q  [$];
    logic                               hit_q      [$];

    int hit_count      = 0;
    bit vectors_loaded = 1'b0;

    top_rtl uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .x_cursor  (x_cursor),
        .y_cursor  (y_cursor),
        .xch       (xch),
        .ych       (ych),
        .beam_on   (beam_on),
        .dac_load  (dac_load),
        .enemy_hit (enemy_hit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting and compares
    ////////////////////////////////////////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_coord(input string name,
                               input logic [vector_pkg::COORD_WIDTH-1:0] actual,
                               input logic [vector_pkg::COORD_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s = %0d, expected %0d",
                     $time, name, actual, expected);
            abort_run("wrong DAC code");
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s = %b, expected %b",
                     $time, name, actual, expected);
            abort_run("wrong control bit");
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("MISMATCH at time %0t: %s = %0d, expected %0d",
                     $time, name, actual, expected);
            abort_run("wrong count");
        end
    endtask

    // sprite point plus offset, wrapping at the screen edge
    function automatic logic [vector_pkg::COORD_WIDTH-1:0] offset_coord(
        input logic [vector_pkg::COORD_WIDTH-1:0] rel,
        input logic [vector_pkg::COORD_WIDTH-1:0] offset
    );
        return rel + offset;
    endfunction

    task automatic load_vectors();
        int    fd;
        int    fields;
        string line;
        int    cx;
        int    cy;
        int    ex;
        int    ey;
        int    hit;

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the vectors file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    // comment and blank lines parse as no fields
                    fields = $sscanf(line, "%h %h %h %h %h", cx, cy, ex, ey, hit);
                    if (fields == 5) begin
                        cursor_x_q.push_back(vector_pkg::COORD_WIDTH'(cx));
                        cursor_y_q.push_back(vector_pkg::COORD_WIDTH'(cy));
                        enemy_x_q.push_back(vector_pkg::COORD_WIDTH'(ex));
                        enemy_y_q.push_back(vector_pkg::COORD_WIDTH'(ey));
                        hit_q.push_back(hit != 0);
                    end
                end
            end
            $fclose(fd);
            if (cursor_x_q.size() == 0) begin
                abort_run("the vectors file holds no frames");
            end
        end
    endtask

    // returns the clocks since the call, outputs sampled as they stood before the edge
    task automatic wait_for_load(input bit idle_check, output int gap);
        gap = 0;
        do begin
            @(posedge clk);
            gap++;
            if (idle_check && dac_load !== 1'b1) begin
                check_coord("xch", xch, '0);
                check_coord("ych", ych, '0);
                check_bit("beam_on", beam_on, 1'b0);
                check_bit("enemy_hit", enemy_hit, 1'b0);
            end
        end while (dac_load !== 1'b1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // hit counter and watchdog
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n && enemy_hit === 1'b1) begin
            hit_count <= hit_count + 1;
        end
    end

    initial begin
        int limit;

        wait (vectors_loaded);
        limit = cursor_x_q.size() * (15 + 15 * (vector_pkg::DWELL_CYCLES + 1)) + 50;
        #(limit * CLK_PERIOD);
        abort_run($sformatf("timeout: no complete run within %0d clock cycles", limit));
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame by frame stimulus and checks
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int                                 gap;
        int                                 idx;
        int                                 seen_hits;
        int                                 num_frames;
        logic [vector_pkg::POINT_WIDTH-1:0] word;
        logic [vector_pkg::COORD_WIDTH-1:0] x_off;
        logic [vector_pkg::COORD_WIDTH-1:0] y_off;

        rst_n    = 1'b0;
        x_cursor = '0;
        y_cursor = '0;
        load_vectors();
        num_frames     = cursor_x_q.size();
        vectors_loaded = 1'b1;

        @(posedge clk);
        x_cursor <= cursor_x_q[0];
        y_cursor <= cursor_y_q[0];
        @(posedge clk);
        rst_n <= 1'b1;

        seen_hits = 0;
        for (int f = 0; f < num_frames; f++) begin
            for (int p = 0; p < SHAPE_PTS; p++) begin
                wait_for_load(f == 0 && p == 0, gap);
                if (p == 0) begin
                    if (f > 0) begin
                        check_count("enemy_hit pulses", hit_count - seen_hits,
                                    int'(hit_q[f-1]));
                        seen_hits = hit_count;
                    end
                end else begin
                    check_count("dac_load spacing", gap, vector_pkg::DWELL_CYCLES + 1);
                end

                if (p < CURSOR_PTS) begin
                    idx   = int'(sprite_pkg::CURSOR_BASE) + p;
                    x_off = cursor_x_q[f];
                    y_off = cursor_y_q[f];
                end else begin
                    idx   = int'(sprite_pkg::ENEMY_BASE) + p - CURSOR_PTS;
                    x_off = enemy_x_q[f];
                    y_off = enemy_y_q[f];
                end
                word = sprite_pkg::SPRITE_TABLE[idx];
                check_coord("xch", xch, offset_coord(
                    word[vector_pkg::X_LSB +: vector_pkg::COORD_WIDTH], x_off));
                check_coord("ych", ych, offset_coord(
                    word[vector_pkg::Y_LSB +: vector_pkg::COORD_WIDTH], y_off));
                check_bit("beam_on", beam_on, word[vector_pkg::BEAM_BIT]);

                // new cursor right after the last load of the frame
                if (p == SHAPE_PTS - 1 && f < num_frames - 1) begin
                    x_cursor <= cursor_x_q[f+1];
                    y_cursor <= cursor_y_q[f+1];
                end
            end
        end

        // a catch at the end of the last frame shows before the next frame draws
        wait_for_load(1'b0, gap);
        check_count("enemy_hit pulses", hit_count - seen_hits, int'(hit_q[num_frames-1]));

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/top_rtl_vectors.txt ====
// columns (hex): cursor x, cursor y, enemy x, enemy y in this frame, hit at end of frame
// the enemy steps toward the cursor of the next line
fa fd f0 f0 0
f5 f3 f1 f1 0
f5 f3 f2 f2 0
f5 f3 f3 f3 0
f5 f3 f4 f3 1
f5 f3 f0 f0 0
ff fa f1 f1 0
ff fa f2 f2 0
ff fa f3 f3 0
ff fa f4 f4 0
ff fa f5 f5 0
ff fa f6 f6 0
ff fa f7 f7 0
ff fa f8 f8 0
ff fa f9 f9 0
ff fa fa fa 1
fb fa f0 f0 0
64 3c ef ef 0
64 3c ee ee 0
00 00 ed ed 0

// ==== verilog.f ====
src/vector_pkg.sv
src/sprite_pkg.sv
src/sprite_rom.sv
src/frame_ram.sv
src/enemy_control.sv
src/memory_manage.sv
src/vector_display.sv
src/top_rtl.sv
verification/top_rtl_tb.sv
